// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= axi_ice40_sram_tb
FILELIST  ?= axi_ice40_sram.f
LOG       ?= sim.log
PASS_MSG  := Testbench passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove obj_dir and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: axi_ice40_sram.f
+incdir+source
source/sram_pkg.sv
source/axi_sram_write.sv
source/axi_sram_read.sv
source/sram_port.sv
source/axi_ice40_sram.sv
tb/sram_model.sv
tb/axi_ice40_sram_tb.sv

// File: source/axi_ice40_sram.sv
`timescale 1ns/1ps
`default_nettype none

`include "sram_consts.svh"

module axi_ice40_sram (
  input  wire                           clk,
  input  wire                           rst_n,

  input  wire                           s_axi_awvalid,
  output logic                          s_axi_awready,
  input  wire  [`AXI_ID_WIDTH-1:0]      s_axi_awid,
  input  wire  [`AXI_ADDR_WIDTH-1:0]    s_axi_awaddr,
  input  wire  [`AXI_LEN_WIDTH-1:0]     s_axi_awlen,
  input  wire  [2:0]                    s_axi_awsize,
  input  wire  [1:0]                    s_axi_awburst,
  input  wire                           s_axi_wvalid,
  output logic                          s_axi_wready,
  input  wire  [`AXI_DATA_WIDTH-1:0]    s_axi_wdata,
  input  wire  [`SRAM_STRB_WIDTH-1:0]   s_axi_wstrb,
  input  wire                           s_axi_wlast,
  output logic                          s_axi_bvalid,
  input  wire                           s_axi_bready,
  output logic [`AXI_ID_WIDTH-1:0]      s_axi_bid,
  output logic [1:0]                    s_axi_bresp,

  input  wire                           s_axi_arvalid,
  output logic                          s_axi_arready,
  input  wire  [`AXI_ID_WIDTH-1:0]      s_axi_arid,
  input  wire  [`AXI_ADDR_WIDTH-1:0]    s_axi_araddr,
  input  wire  [`AXI_LEN_WIDTH-1:0]     s_axi_arlen,
  input  wire  [2:0]                    s_axi_arsize,
  input  wire  [1:0]                    s_axi_arburst,
  output logic                          s_axi_rvalid,
  input  wire                           s_axi_rready,
  output logic [`AXI_ID_WIDTH-1:0]      s_axi_rid,
  output logic [`AXI_DATA_WIDTH-1:0]    s_axi_rdata,
  output logic [1:0]                    s_axi_rresp,
  output logic                          s_axi_rlast,

  output logic [`SRAM_ADDR_WIDTH-1:0]   sram_io_addr,
  inout  wire  [`AXI_DATA_WIDTH-1:0]    sram_io_data,
  output logic                          sram_io_we_n,
  output logic                          sram_io_oe_n,
  output logic                          sram_io_ce_n
);
  import sram_pkg::*;

  sram_req_t wr_req;
  logic      wr_req_valid;
  logic      wr_req_ready;
  logic      wr_done;
  sram_req_t rd_req;
  logic      rd_req_valid;
  logic      rd_req_ready;
  sram_rsp_t rd_rsp;
  logic      rd_rsp_valid;

  // port names line up with the local nets.
  axi_sram_write u_axi_sram_write (.*);

  axi_sram_read u_axi_sram_read (.*);

  sram_port u_sram_port (.*);

endmodule

`default_nettype wire

// File: source/axi_sram_read.sv
`timescale 1ns/1ps
`default_nettype none

`include "sram_consts.svh"

module axi_sram_read (
  input  wire                           clk,
  input  wire                           rst_n,

  input  wire                           s_axi_arvalid,
  output logic                          s_axi_arready,
  input  wire  [`AXI_ID_WIDTH-1:0]      s_axi_arid,
  input  wire  [`AXI_ADDR_WIDTH-1:0]    s_axi_araddr,
  input  wire  [`AXI_LEN_WIDTH-1:0]     s_axi_arlen,
  input  wire  [2:0]                    s_axi_arsize,
  input  wire  [1:0]                    s_axi_arburst,

  output logic                          s_axi_rvalid,
  input  wire                           s_axi_rready,
  output logic [`AXI_ID_WIDTH-1:0]      s_axi_rid,
  output logic [`AXI_DATA_WIDTH-1:0]    s_axi_rdata,
  output logic [1:0]                    s_axi_rresp,
  output logic                          s_axi_rlast,

  output sram_pkg::sram_req_t           rd_req,
  output logic                          rd_req_valid,
  input  wire                           rd_req_ready,
  input  wire  sram_pkg::sram_rsp_t     rd_rsp,
  input  wire                           rd_rsp_valid
);
  import sram_pkg::*;

  burst_t burst;
  logic   active;      // burst open.
  logic   in_flight;   // request issued, data not back yet.
  logic   issue_done;  // final word already requested.
  logic   ar_fire;
  logic   req_fire;
  logic   issue;

  assign s_axi_arready = !active;
  assign s_axi_rid     = burst.id;
  assign s_axi_rresp   = 2'b00;

  assign ar_fire  = s_axi_arvalid && s_axi_arready;
  assign req_fire = rd_req_valid && rd_req_ready;

  // buffer must be empty so the response always has a slot.
  assign issue = active && !issue_done && !in_flight && !s_axi_rvalid;

  // address follows the burst, held until the transfer.
  assign rd_req.addr  = burst.addr;
  assign rd_req.data  = '0;
  assign rd_req.strb  = '1;
  assign rd_req.write = 1'b0;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      active       <= 1'b0;
      in_flight    <= 1'b0;
      issue_done   <= 1'b0;
      rd_req_valid <= 1'b0;
      s_axi_rvalid <= 1'b0;
    end else begin
      if (ar_fire) begin
        active     <= 1'b1;
        issue_done <= 1'b0;
      end

      if (issue) begin
        rd_req_valid <= 1'b1;
        in_flight    <= 1'b1;
      end else if (req_fire) begin
        rd_req_valid <= 1'b0;
        issue_done   <= (burst.remaining == '0);
      end

      if (rd_rsp_valid) begin
        in_flight    <= 1'b0;
        s_axi_rvalid <= 1'b1;
      end else if (s_axi_rvalid && s_axi_rready) begin
        s_axi_rvalid <= 1'b0;
        if (s_axi_rlast) begin
          active <= 1'b0;
        end
      end
    end
  end

  // burst counters and the beat buffer payload.
  always_ff @(posedge clk) begin
    if (ar_fire) begin
      burst.id        <= s_axi_arid;
      burst.addr      <= s_axi_araddr[`AXI_ADDR_WIDTH-1:`AXI_ADDR_WIDTH-`SRAM_ADDR_WIDTH];
      burst.remaining <= s_axi_arlen;
    end else if (req_fire) begin
      burst.addr      <= burst.addr + 1'b1;
      burst.remaining <= burst.remaining - 1'b1;
    end

    if (rd_rsp_valid) begin
      s_axi_rdata <= rd_rsp.data;
      s_axi_rlast <= issue_done;  // word came from the last request.
    end
  end

endmodule

`default_nettype wire

// File: source/axi_sram_write.sv
`timescale 1ns/1ps
`default_nettype none

`include "sram_consts.svh"

module axi_sram_write (
  input  wire                           clk,
  input  wire                           rst_n,

  input  wire                           s_axi_awvalid,
  output logic                          s_axi_awready,
  input  wire  [`AXI_ID_WIDTH-1:0]      s_axi_awid,
  input  wire  [`AXI_ADDR_WIDTH-1:0]    s_axi_awaddr,
  input  wire  [`AXI_LEN_WIDTH-1:0]     s_axi_awlen,
  input  wire  [2:0]                    s_axi_awsize,
  input  wire  [1:0]                    s_axi_awburst,

  input  wire                           s_axi_wvalid,
  output logic                          s_axi_wready,
  input  wire  [`AXI_DATA_WIDTH-1:0]    s_axi_wdata,
  input  wire  [`SRAM_STRB_WIDTH-1:0]   s_axi_wstrb,
  input  wire                           s_axi_wlast,

  output logic                          s_axi_bvalid,
  input  wire                           s_axi_bready,
  output logic [`AXI_ID_WIDTH-1:0]      s_axi_bid,
  output logic [1:0]                    s_axi_bresp,

  output sram_pkg::sram_req_t           wr_req,
  output logic                          wr_req_valid,
  input  wire                           wr_req_ready,
  input  wire                           wr_done
);
  import sram_pkg::*;

  typedef enum logic [1:0] {
    WR_IDLE,
    WR_DATA,
    WR_RESP
  } wr_state_t;

  wr_state_t state;
  burst_t    burst;
  logic      pending;    // word handed to the port, not yet written.
  logic      last_beat;  // pending word closes the burst.
  logic      aw_fire;
  logic      w_fire;

  assign s_axi_awready = (state == WR_IDLE);
  assign s_axi_wready  = (state == WR_DATA) && !pending;
  assign s_axi_bvalid  = (state == WR_RESP);
  assign s_axi_bid     = burst.id;
  assign s_axi_bresp   = 2'b00;  // always OKAY.

  assign aw_fire = s_axi_awvalid && s_axi_awready;
  assign w_fire  = s_axi_wvalid && s_axi_wready;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state        <= WR_IDLE;
      pending      <= 1'b0;
      last_beat    <= 1'b0;
      wr_req_valid <= 1'b0;
    end else begin
      if (wr_req_valid && wr_req_ready) begin
        wr_req_valid <= 1'b0;
      end

      case (state)
        WR_IDLE: begin
          if (aw_fire) begin
            state <= WR_DATA;
          end
        end
        WR_DATA: begin
          if (w_fire) begin
            pending      <= 1'b1;
            wr_req_valid <= 1'b1;
            last_beat    <= s_axi_wlast || (burst.remaining == '0);
          end
          if (wr_done) begin
            pending <= 1'b0;
            if (last_beat) begin
              state <= WR_RESP;
            end
          end
        end
        WR_RESP: begin
          if (s_axi_bready) begin
            state <= WR_IDLE;
          end
        end
        default: state <= WR_IDLE;
      endcase
    end
  end

  // burst tracking and word payload.
  always_ff @(posedge clk) begin
    if (aw_fire) begin
      burst.id        <= s_axi_awid;
      burst.addr      <= s_axi_awaddr[`AXI_ADDR_WIDTH-1:`AXI_ADDR_WIDTH-`SRAM_ADDR_WIDTH];
      burst.remaining <= s_axi_awlen;
    end else if (w_fire) begin
      burst.addr      <= burst.addr + 1'b1;  // INCR only.
      burst.remaining <= burst.remaining - 1'b1;
    end

    if (w_fire) begin
      wr_req.addr  <= burst.addr;
      wr_req.data  <= s_axi_wdata;
      wr_req.strb  <= s_axi_wstrb;
      wr_req.write <= 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: source/sram_consts.svh
`ifndef SRAM_CONSTS_SVH
`define SRAM_CONSTS_SVH

// AXI side.
`define AXI_ADDR_WIDTH 16
`define AXI_DATA_WIDTH 16
`define AXI_ID_WIDTH 4

// SRAM side, word addressed.
`define SRAM_STRB_WIDTH 2
`define SRAM_ADDR_WIDTH 15     // byte address minus lane bits.

// clocks one pin access holds ce_n low.
`define SRAM_ACCESS_CYCLES 2

// burst length field is fixed by AXI4.
`define AXI_LEN_WIDTH 8

`endif

// File: source/sram_pkg.sv
`default_nettype none

`include "sram_consts.svh"

package sram_pkg;

  // one captured AW or AR request.
  typedef struct packed {
    logic [`AXI_ID_WIDTH-1:0]    id;
    logic [`SRAM_ADDR_WIDTH-1:0] addr;       // word address of the next beat.
    logic [`AXI_LEN_WIDTH-1:0]   remaining;  // beats left after the current one.
  } burst_t;

  // one word request to the SRAM port.
  typedef struct packed {
    logic [`SRAM_ADDR_WIDTH-1:0] addr;
    logic [`AXI_DATA_WIDTH-1:0]  data;
    logic [`SRAM_STRB_WIDTH-1:0] strb;
    logic                        write;
  } sram_req_t;

  // read data back from the port.
  typedef struct packed {
    logic [`AXI_DATA_WIDTH-1:0] data;
  } sram_rsp_t;

endpackage

`default_nettype wire

// File: source/sram_port.sv
`timescale 1ns/1ps
`default_nettype none

`include "sram_consts.svh"

module sram_port (
  input  wire                           clk,
  input  wire                           rst_n,

  input  wire  sram_pkg::sram_req_t     wr_req,
  input  wire                           wr_req_valid,
  output logic                          wr_req_ready,
  output logic                          wr_done,

  input  wire  sram_pkg::sram_req_t     rd_req,
  input  wire                           rd_req_valid,
  output logic                          rd_req_ready,
  output sram_pkg::sram_rsp_t           rd_rsp,
  output logic                          rd_rsp_valid,

  output logic [`SRAM_ADDR_WIDTH-1:0]   sram_io_addr,
  inout  wire  [`AXI_DATA_WIDTH-1:0]    sram_io_data,
  output logic                          sram_io_we_n,
  output logic                          sram_io_oe_n,
  output logic                          sram_io_ce_n
);
  import sram_pkg::*;

  localparam int CNT_W = $clog2(`SRAM_ACCESS_CYCLES + 1);

  sram_req_t                  cur;
  sram_req_t                  next_req;
  logic                       busy;
  logic                       rmw;       // read phase of a partial write.
  logic                       last_wr;   // write path won the last grant.
  logic [CNT_W-1:0]           cnt;
  logic                       data_oe;
  logic [`AXI_DATA_WIDTH-1:0] data_out;
  logic [`AXI_DATA_WIDTH-1:0] merged;
  logic                       take;

  // loser of the last grant goes first.
  assign wr_req_ready = !busy && (!rd_req_valid || !last_wr);
  assign rd_req_ready = !busy && (!wr_req_valid || last_wr);

  assign take     = (wr_req_valid && wr_req_ready) || (rd_req_valid && rd_req_ready);
  assign next_req = (wr_req_valid && wr_req_ready) ? wr_req : rd_req;

  assign sram_io_data = data_oe ? data_out : 'z;

  always_comb begin
    for (int b = 0; b < `SRAM_STRB_WIDTH; b++) begin
      merged[b*8+:8] = cur.strb[b] ? cur.data[b*8+:8] : sram_io_data[b*8+:8];
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      busy         <= 1'b0;
      rmw          <= 1'b0;
      last_wr      <= 1'b0;
      cnt          <= '0;
      sram_io_ce_n <= 1'b1;
      sram_io_we_n <= 1'b1;
      sram_io_oe_n <= 1'b1;
      data_oe      <= 1'b0;
      wr_done      <= 1'b0;
      rd_rsp_valid <= 1'b0;
    end else begin
      wr_done      <= 1'b0;
      rd_rsp_valid <= 1'b0;
      if (!busy && take) begin
        busy         <= 1'b1;
        last_wr      <= next_req.write;
        cur          <= next_req;
        cnt          <= '0;
        rmw          <= next_req.write && (next_req.strb != '1);
        sram_io_addr <= next_req.addr;
        sram_io_ce_n <= 1'b0;
        sram_io_we_n <= !(next_req.write && (next_req.strb == '1));
        sram_io_oe_n <= next_req.write && (next_req.strb == '1);
        data_oe      <= next_req.write && (next_req.strb == '1);
        data_out     <= next_req.data;
      end else if (busy && cnt != CNT_W'(`SRAM_ACCESS_CYCLES - 1)) begin
        cnt          <= cnt + 1'b1;
        sram_io_we_n <= 1'b1;  // store edge after the first cycle.
      end else if (busy && rmw) begin
        rmw          <= 1'b0;
        cnt          <= '0;
        sram_io_oe_n <= 1'b1;
        sram_io_we_n <= 1'b0;
        data_oe      <= 1'b1;
        data_out     <= merged;
      end else if (busy) begin
        busy         <= 1'b0;
        sram_io_ce_n <= 1'b1;
        sram_io_we_n <= 1'b1;
        sram_io_oe_n <= 1'b1;
        data_oe      <= 1'b0;
        wr_done      <= cur.write;
        rd_rsp_valid <= !cur.write;
        rd_rsp.data  <= sram_io_data;  // sampled at the end of the read.
      end
    end
  end

endmodule

`default_nettype wire

// File: tb/axi_ice40_sram_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "sram_consts.svh"

module axi_ice40_sram_tb;

  localparam int CLK_PERIOD  = 100;
  localparam int TOTAL_BEATS = 96;  // all bursts below, both directions.

  typedef struct packed {
    logic [`AXI_DATA_WIDTH-1:0]  data;
    logic [`SRAM_STRB_WIDTH-1:0] strb;
  } w_beat_t;

  logic                        clk;
  logic                        rst_n;
  logic                        s_axi_awvalid, s_axi_awready;
  logic [`AXI_ID_WIDTH-1:0]    s_axi_awid, s_axi_arid, s_axi_bid, s_axi_rid;
  logic [`AXI_ADDR_WIDTH-1:0]  s_axi_awaddr, s_axi_araddr;
  logic [`AXI_LEN_WIDTH-1:0]   s_axi_awlen, s_axi_arlen;
  logic [2:0]                  s_axi_awsize, s_axi_arsize;
  logic [1:0]                  s_axi_awburst, s_axi_arburst;
  logic                        s_axi_wvalid, s_axi_wready, s_axi_wlast;
  logic [`AXI_DATA_WIDTH-1:0]  s_axi_wdata, s_axi_rdata;
  logic [`SRAM_STRB_WIDTH-1:0] s_axi_wstrb;
  logic                        s_axi_bvalid, s_axi_bready;
  logic [1:0]                  s_axi_bresp, s_axi_rresp;
  logic                        s_axi_arvalid, s_axi_arready;
  logic                        s_axi_rvalid, s_axi_rready, s_axi_rlast;
  logic [`SRAM_ADDR_WIDTH-1:0] sram_io_addr;
  wire  [`AXI_DATA_WIDTH-1:0]  sram_io_data;
  logic                        sram_io_we_n, sram_io_oe_n, sram_io_ce_n;

  logic [31:0]                 rng;
  logic [7:0]                  sb [0:(1 << `SRAM_ADDR_WIDTH)-1][0:`SRAM_STRB_WIDTH-1];
  logic [`AXI_DATA_WIDTH-1:0]  beat_buf [0:255];
  w_beat_t                     w_q [$];
  logic [`AXI_DATA_WIDTH-1:0]  r_exp [$];
  logic [`AXI_ID_WIDTH-1:0]    b_id, r_id;
  logic                        aw_pend, ar_pend, bp_en;
  logic [`SRAM_ADDR_WIDTH-1:0] base, burst_base;
  int                          b_wait, err_cnt, err_mark, tests_run, tests_failed;

  axi_ice40_sram u_axi_ice40_sram (.*);

  sram_model u_sram_model (
    .addr(sram_io_addr), .data(sram_io_data),
    .we_n(sram_io_we_n), .oe_n(sram_io_oe_n), .ce_n(sram_io_ce_n)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(CLK_PERIOD * (TOTAL_BEATS * 20 + 1000));
    $display("watchdog expired, the DUT stopped answering");
    $display("Testbench failed");
    $finish;
  end

  // R and B hold while the master stalls.
  assert property (@(posedge clk) disable iff (!rst_n)
    s_axi_rvalid && !s_axi_rready |=> s_axi_rvalid && $stable({s_axi_rdata, s_axi_rid, s_axi_rlast}))
    else note_failure("R beat changed or dropped while rready was low");

  assert property (@(posedge clk) disable iff (!rst_n)
    s_axi_bvalid && !s_axi_bready |=> s_axi_bvalid && $stable(s_axi_bid))
    else note_failure("B response changed or dropped while bready was low");

  function automatic logic [31:0] next_rand();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  // 16-word aligned so a burst stays inside its region.
  function automatic logic [`SRAM_ADDR_WIDTH-1:0] rand_addr(input logic [2:0] region);
    logic [31:0] r;
    r = next_rand();
    return {region, r[11:4], 4'h0};
  endfunction

  task automatic note_failure(input string what);
    err_cnt++;
    $display("%s at %0t ns", what, $time);
  endtask

  task automatic expect_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      err_cnt++;
      $display("ERR %s got 0x%h expected 0x%h at %0t ns", name, got, exp, $time);
    end
  endtask

  task automatic fill_random(input int n);
    int          i;
    logic [31:0] r;
    for (i = 0; i < n; i++) begin
      r           = next_rand();
      beat_buf[i] = r[`AXI_DATA_WIDTH-1:0];
    end
  endtask

  task automatic post_write(input logic [`AXI_ID_WIDTH-1:0] id,
                            input logic [`SRAM_ADDR_WIDTH-1:0] waddr, input int n,
                            input logic [`SRAM_STRB_WIDTH-1:0] strb);
    int                          i;
    int                          l;
    logic [`SRAM_ADDR_WIDTH-1:0] a;
    s_axi_awid   = id;
    s_axi_awaddr = {waddr, 1'b0};
    s_axi_awlen  = n - 1;
    aw_pend      = 1'b1;
    b_id         = id;
    b_wait++;
    for (i = 0; i < n; i++) begin
      a = waddr + i;
      w_q.push_back({beat_buf[i], strb});
      for (l = 0; l < `SRAM_STRB_WIDTH; l++) begin
        if (strb[l]) sb[a][l] = beat_buf[i][l*8 +: 8];  // unselected lanes keep old bytes.
      end
    end
  endtask

  task automatic post_read(input logic [`AXI_ID_WIDTH-1:0] id,
                           input logic [`SRAM_ADDR_WIDTH-1:0] waddr, input int n);
    int                          i;
    logic [`SRAM_ADDR_WIDTH-1:0] a;
    s_axi_arid   = id;
    s_axi_araddr = {waddr, 1'b0};
    s_axi_arlen  = n - 1;
    ar_pend      = 1'b1;
    r_id         = id;
    for (i = 0; i < n; i++) begin
      a = waddr + i;
      r_exp.push_back({sb[a][1], sb[a][0]});
    end
  endtask

  // runs 10 ns after each edge. handshakes seen here land on the next edge.
  task automatic run_traffic();
    logic [31:0] r;
    while (aw_pend || ar_pend || w_q.size() != 0 || b_wait != 0 || r_exp.size() != 0) begin
      r = next_rand();
      s_axi_awvalid = aw_pend;
      s_axi_arvalid = ar_pend;
      if (aw_pend && s_axi_awready) aw_pend = 1'b0;
      if (ar_pend && s_axi_arready) ar_pend = 1'b0;
      s_axi_wvalid = (w_q.size() != 0);
      if (w_q.size() != 0) begin
        s_axi_wdata = w_q[0].data;
        s_axi_wstrb = w_q[0].strb;
        s_axi_wlast = (w_q.size() == 1);
        if (s_axi_wready) void'(w_q.pop_front());
      end
      s_axi_bready = !bp_en || r[0];
      if (s_axi_bvalid && s_axi_bready) begin
        assert (b_wait != 0) else note_failure("B response with no write outstanding");
        expect_eq("s_axi_bid", s_axi_bid, b_id);
        expect_eq("s_axi_bresp", s_axi_bresp, 0);
        if (b_wait != 0) b_wait--;
      end
      s_axi_rready = !bp_en || r[1];
      if (s_axi_rvalid && s_axi_rready) begin
        assert (r_exp.size() != 0) else note_failure("R beat with no read outstanding");
        if (r_exp.size() != 0) begin
          expect_eq("s_axi_rdata", s_axi_rdata, r_exp[0]);
          expect_eq("s_axi_rid", s_axi_rid, r_id);
          expect_eq("s_axi_rresp", s_axi_rresp, 0);
          expect_eq("s_axi_rlast", s_axi_rlast, r_exp.size() == 1);
          void'(r_exp.pop_front());
        end
      end
      @(posedge clk);
      #10;
    end
    settle_idle();
  endtask

  // no stray response may follow.
  task automatic settle_idle();
    s_axi_awvalid = 1'b0;
    s_axi_arvalid = 1'b0;
    s_axi_wvalid  = 1'b0;
    s_axi_wlast   = 1'b0;
    s_axi_bready  = 1'b1;
    s_axi_rready  = 1'b1;
    repeat (4) begin
      @(posedge clk);
      #10;
      assert (!s_axi_bvalid && !s_axi_rvalid) else note_failure("response after the last beat");
    end
  endtask

  task automatic report_test(input string name);
    tests_run++;
    if (err_cnt == err_mark) begin
      $display("test %0d %s: ok", tests_run, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: %0d errors", tests_run, name, err_cnt - err_mark);
    end
    err_mark = err_cnt;
  endtask

  initial begin
    rng = 32'd88;
    {err_cnt, err_mark, tests_run, tests_failed, b_wait} = '0;
    {aw_pend, ar_pend, bp_en} = '0;
    rst_n = 1'b0;
    {s_axi_awvalid, s_axi_wvalid, s_axi_wlast, s_axi_arvalid} = '0;
    {s_axi_awid, s_axi_awaddr, s_axi_awlen, s_axi_arid, s_axi_araddr, s_axi_arlen} = '0;
    {s_axi_wdata, s_axi_wstrb} = '0;
    {s_axi_awsize, s_axi_arsize} = {3'd1, 3'd1};      // two bytes per beat.
    {s_axi_awburst, s_axi_arburst} = {2'b01, 2'b01};  // INCR.
    {s_axi_bready, s_axi_rready} = 2'b11;
    repeat (2) @(posedge clk);
    #10;
    rst_n = 1'b1;

    expect_eq("s_axi_bvalid", s_axi_bvalid, 0);
    expect_eq("s_axi_rvalid", s_axi_rvalid, 0);
    expect_eq("sram_io_ce_n", sram_io_ce_n, 1);
    expect_eq("s_axi_awready", s_axi_awready, 1);
    expect_eq("s_axi_arready", s_axi_arready, 1);
    report_test("after reset");

    fill_random(1);
    base = rand_addr(3'd0);
    post_write(4'h3, base, 1, 2'b11);
    run_traffic();
    post_read(4'h5, base, 1);
    run_traffic();
    report_test("single beat");

    fill_random(8);
    burst_base = rand_addr(3'd1);
    post_write(4'h6, burst_base, 8, 2'b11);
    run_traffic();
    post_read(4'h9, burst_base, 8);
    run_traffic();
    report_test("8-beat burst");

    beat_buf[0] = 16'h1234;
    beat_buf[1] = 16'habcd;
    post_write(4'h1, 15'h4000, 2, 2'b11);
    run_traffic();
    beat_buf[0] = 16'hee77;
    post_write(4'h2, 15'h4000, 1, 2'b01);  // low byte only.
    run_traffic();
    beat_buf[0] = 16'h99cc;
    post_write(4'h2, 15'h4001, 1, 2'b10);
    run_traffic();
    post_read(4'h4, 15'h4000, 2);
    run_traffic();
    report_test("partial strobes");

    bp_en = 1'b1;
    fill_random(16);
    base = rand_addr(3'd5);
    post_write(4'ha, base, 16, 2'b11);
    run_traffic();
    post_read(4'hb, base, 16);
    run_traffic();
    bp_en = 1'b0;
    report_test("back-pressure");

    fill_random(16);
    base = rand_addr(3'd6);
    post_write(4'hc, base, 16, 2'b11);
    post_read(4'hd, burst_base, 8);  // issued with the write into another region.
    run_traffic();
    post_read(4'he, base, 16);
    run_traffic();
    report_test("concurrent paths");

    $display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, err_cnt);
    if (err_cnt == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tb/sram_model.sv
`timescale 1ns/1ps
`default_nettype none

`include "sram_consts.svh"

module sram_model (
  input  wire [`SRAM_ADDR_WIDTH-1:0] addr,
  inout  wire [`AXI_DATA_WIDTH-1:0]  data,
  input  wire                        we_n,
  input  wire                        oe_n,
  input  wire                        ce_n
);

  logic [`AXI_DATA_WIDTH-1:0] mem [0:(1 << `SRAM_ADDR_WIDTH)-1];

  // part drives the bus only for a plain read.
  assign data = (!ce_n && !oe_n && we_n) ? mem[addr] : 'z;

  always @(posedge we_n) begin
    if (!ce_n) begin
      mem[addr] <= data;  // latched as we_n rises.
    end
  end

  initial begin
    int          i;
    logic [31:0] fill;
    for (i = 0; i < (1 << `SRAM_ADDR_WIDTH); i++) begin
      fill   = (i * 40503) ^ 32'h5a3c;  // every address bit counts.
      mem[i] = fill[`AXI_DATA_WIDTH-1:0];
    end
  end

endmodule

`default_nettype wire
